// ==== hw/ptw_pkg.sv ====
// walker widths, pte bit positions, state/access/select enums and packed structs
`default_nettype none

package ptw_pkg;

  //========================================
  // address format
  //========================================
  localparam int PADDR_WIDTH   = 40;
  localparam int VPN_WIDTH     = 27;
  localparam int PPN_WIDTH     = 28;
  localparam int VPN_PER_LEVEL = 9;
  localparam int FLG_WIDTH     = 16;
  localparam int PTE_WIDTH     = 64;
  localparam int PGS_WIDTH     = 3;

  // pte bit positions
  localparam int PTE_V  = 0;
  localparam int PTE_H  = 6;
  localparam int PTE_P  = 7;
  localparam int PTE_W  = 8;
  localparam int PTE_HG = 12;
  localparam int PTE_NX = 63;

  //========================================
  // enums
  //========================================
  typedef enum logic [1:0] {
    ACC_FETCH = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } ptw_acc_e;

  typedef enum logic [4:0] {
    PTW_IDLE     = 5'd0,
    PTW_FST_DATA = 5'd1,
    PTW_FST_CHK  = 5'd2,
    PTW_SCD_DATA = 5'd3,
    PTW_SCD_CHK  = 5'd4,
    PTW_THD_DATA = 5'd5,
    PTW_THD_CHK  = 5'd6,
    PTW_ACC_FLT  = 5'd7,
    PTW_PGE_FLT  = 5'd8,
    PTW_DATA_VLD = 5'd9
  } ptw_state_e;

  // address generator load select
  typedef enum logic [1:0] {
    SEL_HOLD = 2'd0,
    SEL_FST  = 2'd1,
    SEL_SCD  = 2'd2,
    SEL_THD  = 2'd3
  } ptw_addr_sel_e;

  //========================================
  // structs
  //========================================
  typedef struct packed {
    logic [VPN_WIDTH-1:0] vpn;
    ptw_acc_e             acc;
  } ptw_walk_req_t;

  // one-hot page size
  typedef struct packed {
    logic g1;
    logic m2;
    logic k4;
  } ptw_pgs_t;

  // refill vpn carries one spare top bit, always zero
  typedef struct packed {
    logic [VPN_WIDTH:0]   vpn;
    logic [PPN_WIDTH-1:0] ppn;
    ptw_pgs_t             pgs;
    logic [FLG_WIDTH-1:0] flg;
    logic                 g;
  } ptw_refill_t;

endpackage

`default_nettype wire

// ==== hw/ptw_walk_ctrl.sv ====
// walk FSM, request latch, address select and completion decode
`default_nettype none

module ptw_walk_ctrl (
  input  wire logic                      ptw_clk,
  input  wire logic                      cpurst_b,
  input  wire logic                      walk_req,
  input  wire ptw_pkg::ptw_walk_req_t    walk_info,
  input  wire logic                      mem_vld,
  input  wire logic                      mem_err,
  input  wire logic                      pte_leaf,
  input  wire logic                      pte_fault,
  input  wire logic                      ref_grant,
  output ptw_pkg::ptw_state_e            state,
  output logic [ptw_pkg::VPN_WIDTH-1:0]  vpn,
  output ptw_pkg::ptw_acc_e              acc,
  output ptw_pkg::ptw_addr_sel_e         addr_sel,
  output logic                           walk_busy,
  output logic                           mem_req,
  output logic                           ref_vld,
  output logic                           ref_cmplt,
  output logic                           ref_data_vld,
  output logic                           ref_acc_err,
  output logic                           ref_pgflt
);

  import ptw_pkg::*;

  ptw_state_e nxt_state;
  logic       walk_acc;

  // request taken only from idle
  assign walk_acc = (state == PTW_IDLE) && walk_req;

  //========================================
  // state machine
  //========================================
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= PTW_IDLE;
    else
      state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = state;
    case (state)
      PTW_IDLE:
        if (walk_req)
          nxt_state = PTW_FST_DATA;
      PTW_FST_DATA, PTW_SCD_DATA, PTW_THD_DATA:
      begin
        if (mem_err)
          nxt_state = PTW_ACC_FLT;
        else if (mem_vld)
          nxt_state = ptw_state_e'(state + 5'd1);
      end
      PTW_FST_CHK, PTW_SCD_CHK, PTW_THD_CHK:
      begin
        if (pte_fault)
          nxt_state = PTW_PGE_FLT;
        else if (pte_leaf)
          nxt_state = PTW_DATA_VLD;
        else
          nxt_state = ptw_state_e'(state + 5'd1);
      end
      PTW_DATA_VLD:
        if (ref_grant)
          nxt_state = PTW_IDLE;
      default:
        nxt_state = PTW_IDLE;
    endcase
  end

  // request latch
  always_ff @(posedge ptw_clk)
  begin
    if (walk_acc)
    begin
      vpn <= walk_info.vpn;
      acc <= walk_info.acc;
    end
  end

  // next entry address follows each returned entry
  always_comb
  begin
    if (walk_acc)
      addr_sel = SEL_FST;
    else if ((state == PTW_FST_DATA) && mem_vld)
      addr_sel = SEL_SCD;
    else if ((state == PTW_SCD_DATA) && mem_vld)
      addr_sel = SEL_THD;
    else
      addr_sel = SEL_HOLD;
  end

  //========================================
  // outputs
  //========================================
  assign walk_busy    = (state != PTW_IDLE);
  assign mem_req      = (state == PTW_FST_DATA) || (state == PTW_SCD_DATA)
                     || (state == PTW_THD_DATA);
  assign ref_vld      = (state == PTW_DATA_VLD);
  assign ref_data_vld = ref_vld && ref_grant;
  assign ref_acc_err  = (state == PTW_ACC_FLT);
  assign ref_pgflt    = (state == PTW_PGE_FLT);
  assign ref_cmplt    = ref_acc_err || ref_pgflt || ref_data_vld;

endmodule

`default_nettype wire

// ==== hw/ptw_addr_gen.sv ====
// entry address computation and memory request address register
`default_nettype none

module ptw_addr_gen (
  input  wire logic                          ptw_clk,
  input  wire logic                          cpurst_b,
  input  wire ptw_pkg::ptw_addr_sel_e        addr_sel,
  input  wire logic [ptw_pkg::VPN_WIDTH-1:0] vpn,
  input  wire logic [ptw_pkg::VPN_WIDTH-1:0] walk_vpn,
  input  wire logic [ptw_pkg::PPN_WIDTH-1:0] satp_ppn,
  input  wire logic [ptw_pkg::PTE_WIDTH-1:0] mem_data,
  output logic [ptw_pkg::PADDR_WIDTH-1:0]    mem_addr
);

  import ptw_pkg::*;

  logic [PPN_WIDTH-1:0]   nxt_ppn;
  logic [PADDR_WIDTH-1:0] fst_addr;
  logic [PADDR_WIDTH-1:0] scd_addr;
  logic [PADDR_WIDTH-1:0] thd_addr;

  // ppn field of the entry just returned
  assign nxt_ppn = mem_data[PPN_WIDTH+11:12];

  // root level indexes with the unlatched vpn in the accept cycle
  assign fst_addr = {satp_ppn, walk_vpn[VPN_WIDTH-1:2*VPN_PER_LEVEL], 3'b000};
  assign scd_addr = {nxt_ppn, vpn[2*VPN_PER_LEVEL-1:VPN_PER_LEVEL], 3'b000};
  assign thd_addr = {nxt_ppn, vpn[VPN_PER_LEVEL-1:0], 3'b000};

  //========================================
  // request address register
  //========================================
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      mem_addr <= '0;
    else
    begin
      case (addr_sel)
        SEL_FST:
          mem_addr <= fst_addr;
        SEL_SCD:
          mem_addr <= scd_addr;
        SEL_THD:
          mem_addr <= thd_addr;
        default:
          mem_addr <= mem_addr;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/ptw_pte_check.sv ====
// entry register, leaf detection and page fault rules
`default_nettype none

module ptw_pte_check (
  input  wire logic                          ptw_clk,
  input  wire logic                          cpurst_b,
  input  wire logic                          mem_vld,
  input  wire logic [ptw_pkg::PTE_WIDTH-1:0] mem_data,
  input  wire ptw_pkg::ptw_state_e           state,
  input  wire ptw_pkg::ptw_acc_e             acc,
  output logic [ptw_pkg::PTE_WIDTH-1:0]      pte,
  output logic                               pte_leaf,
  output logic                               pte_fault,
  output ptw_pkg::ptw_pgs_t                  leaf_pgs
);

  import ptw_pkg::*;

  logic pte_huge;
  logic hit_1g;
  logic hit_2m;
  logic chk_thd;
  logic perm_flt;
  logic align_flt;

  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      pte <= '0;
    else if (mem_vld)
      pte <= mem_data;
  end

  //========================================
  // leaf detection
  //========================================
  assign pte_huge = pte[PTE_H] && pte[PTE_P] && pte[PTE_V];
  assign hit_1g   = (state == PTW_FST_CHK) && pte_huge;
  assign hit_2m   = (state == PTW_SCD_CHK) && pte_huge;
  // last level always ends the walk
  assign chk_thd  = (state == PTW_THD_CHK);

  assign pte_leaf = hit_1g || hit_2m || chk_thd;
  assign leaf_pgs = '{g1: hit_1g, m2: hit_2m, k4: chk_thd};

  // permission rules
  assign perm_flt = !pte[PTE_V]
                 || ((acc == ACC_STORE) && !pte[PTE_W])
                 || ((acc == ACC_FETCH) && pte[PTE_NX]);

  // superpage ppn must be aligned to its size
  assign align_flt = (hit_1g && (|pte[29:13])) || (hit_2m && (|pte[20:13]));

  assign pte_fault = pte_leaf && (perm_flt || align_flt);

endmodule

`default_nettype wire

// ==== hw/ptw_refill_out.sv ====
// page size and global bit registers, refill entry assembly
`default_nettype none

module ptw_refill_out (
  input  wire logic                          ptw_clk,
  input  wire logic                          cpurst_b,
  input  wire ptw_pkg::ptw_state_e           state,
  input  wire logic [ptw_pkg::PTE_WIDTH-1:0] pte,
  input  wire logic                          pte_leaf,
  input  wire ptw_pkg::ptw_pgs_t             leaf_pgs,
  input  wire logic [ptw_pkg::VPN_WIDTH-1:0] vpn,
  output ptw_pkg::ptw_refill_t               ref_entry
);

  import ptw_pkg::*;

  ptw_pgs_t             ref_pgs;
  logic                 ref_g;
  logic                 ppn_12;
  logic                 leaf_4k;
  logic [VPN_WIDTH:0]   ref_vpn;
  logic [FLG_WIDTH-1:0] ref_flg;

  assign leaf_4k = (state == PTW_THD_CHK);

  // captured in the check cycle that finds the leaf
  always_ff @(posedge ptw_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ref_pgs <= '0;
      ref_g   <= 1'b0;
      ppn_12  <= 1'b0;
    end
    else if (pte_leaf)
    begin
      ref_pgs <= leaf_pgs;
      ref_g   <= leaf_4k ? pte[PTE_H] : pte[PTE_HG];
      ppn_12  <= leaf_4k ? pte[12] : 1'b0;
    end
  end

  // vpn masked down to page size
  always_comb
  begin
    if (ref_pgs.g1)
      ref_vpn = {1'b0, vpn[VPN_WIDTH-1:2*VPN_PER_LEVEL], {(2*VPN_PER_LEVEL){1'b0}}};
    else if (ref_pgs.m2)
      ref_vpn = {1'b0, vpn[VPN_WIDTH-1:VPN_PER_LEVEL], {VPN_PER_LEVEL{1'b0}}};
    else
      ref_vpn = {1'b0, vpn};
  end

  // nx/attr bits, hg, then low permission bits
  assign ref_flg = {3'b000, pte[63:61], pte[12], pte[8:0]};

  assign ref_entry = '{vpn: ref_vpn,
                       ppn: {pte[PADDR_WIDTH-1:13], ppn_12},
                       pgs: ref_pgs,
                       flg: ref_flg,
                       g:   ref_g};

endmodule

`default_nettype wire

// ==== hw/ptw_top.sv ====
// page table walker top level, instances and wires
`default_nettype none

module ptw_top (
  input  wire logic                          ptw_clk,
  input  wire logic                          cpurst_b,
  input  wire logic                          walk_req,
  input  wire ptw_pkg::ptw_walk_req_t        walk_info,
  input  wire logic [ptw_pkg::PPN_WIDTH-1:0] satp_ppn,
  output logic                               walk_busy,
  output logic                               mem_req,
  output logic [ptw_pkg::PADDR_WIDTH-1:0]    mem_addr,
  input  wire logic                          mem_vld,
  input  wire logic [ptw_pkg::PTE_WIDTH-1:0] mem_data,
  input  wire logic                          mem_err,
  output logic                               ref_vld,
  output ptw_pkg::ptw_refill_t               ref_entry,
  input  wire logic                          ref_grant,
  output logic                               ref_cmplt,
  output logic                               ref_data_vld,
  output logic                               ref_acc_err,
  output logic                               ref_pgflt
);

  import ptw_pkg::*;

  ptw_state_e           state;
  logic [VPN_WIDTH-1:0] vpn;
  ptw_acc_e             acc;
  ptw_addr_sel_e        addr_sel;
  logic [PTE_WIDTH-1:0] pte;
  logic                 pte_leaf;
  logic                 pte_fault;
  ptw_pgs_t             leaf_pgs;

  //========================================
  // walk stages
  //========================================
  ptw_walk_ctrl ptw_walk_ctrl_i (
    .ptw_clk      (ptw_clk),
    .cpurst_b     (cpurst_b),
    .walk_req     (walk_req),
    .walk_info    (walk_info),
    .mem_vld      (mem_vld),
    .mem_err      (mem_err),
    .pte_leaf     (pte_leaf),
    .pte_fault    (pte_fault),
    .ref_grant    (ref_grant),
    .state        (state),
    .vpn          (vpn),
    .acc          (acc),
    .addr_sel     (addr_sel),
    .walk_busy    (walk_busy),
    .mem_req      (mem_req),
    .ref_vld      (ref_vld),
    .ref_cmplt    (ref_cmplt),
    .ref_data_vld (ref_data_vld),
    .ref_acc_err  (ref_acc_err),
    .ref_pgflt    (ref_pgflt)
  );

  ptw_addr_gen ptw_addr_gen_i (
    .ptw_clk  (ptw_clk),
    .cpurst_b (cpurst_b),
    .addr_sel (addr_sel),
    .vpn      (vpn),
    .walk_vpn (walk_info.vpn),
    .satp_ppn (satp_ppn),
    .mem_data (mem_data),
    .mem_addr (mem_addr)
  );

  ptw_pte_check ptw_pte_check_i (
    .ptw_clk   (ptw_clk),
    .cpurst_b  (cpurst_b),
    .mem_vld   (mem_vld),
    .mem_data  (mem_data),
    .state     (state),
    .acc       (acc),
    .pte       (pte),
    .pte_leaf  (pte_leaf),
    .pte_fault (pte_fault),
    .leaf_pgs  (leaf_pgs)
  );

  ptw_refill_out ptw_refill_out_i (
    .ptw_clk   (ptw_clk),
    .cpurst_b  (cpurst_b),
    .state     (state),
    .pte       (pte),
    .pte_leaf  (pte_leaf),
    .leaf_pgs  (leaf_pgs),
    .vpn       (vpn),
    .ref_entry (ref_entry)
  );

endmodule

`default_nettype wire

// ==== verif/ptw_tb_tasks.svh ====
// page table setup, walk driver, compare tasks and directed tests

function automatic logic [PTE_WIDTH-1:0] make_pte(input logic [2:0] top,
                                                  input logic [PPN_WIDTH-1:0] ppn,
                                                  input logic [11:0] low);
  return {top, 21'h0, ppn, low};
endfunction

function automatic logic [PADDR_WIDTH-1:0] lvl_addr(input logic [PPN_WIDTH-1:0] ppn,
                                                    input logic [8:0] idx);
  return {ppn, idx, 3'b000};
endfunction

// expected refill from the leaf entry and page size
function automatic ptw_refill_t exp_refill(input logic [PTE_WIDTH-1:0] pte,
                                           input logic [VPN_WIDTH-1:0] vpn,
                                           input ptw_pgs_t pgs);
  ptw_refill_t e;
  e     = '0;
  e.pgs = pgs;
  e.g   = pgs.k4 ? pte[6] : pte[12];
  e.vpn = {1'b0, vpn};
  if (pgs.g1)
    e.vpn[17:0] = '0;
  if (pgs.m2)
    e.vpn[8:0] = '0;
  // huge pages drop entry bit 12 from the ppn
  e.ppn = pte[39:12];
  if (!pgs.k4)
    e.ppn[0] = 1'b0;
  e.flg[12:10] = pte[63:61];
  e.flg[9]     = pte[12];
  e.flg[8:0]   = pte[8:0];
  return e;
endfunction

task automatic cmp_addr(input string name, input logic [PADDR_WIDTH-1:0] got,
                        input logic [PADDR_WIDTH-1:0] exp);
  if (got !== exp)
  begin
    $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

task automatic cmp_refill(input string name, input ptw_refill_t got, input ptw_refill_t exp);
  if (got !== exp)
  begin
    $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

task automatic cmp_status(input string name, input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp)
  begin
    $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

// one walk, with the TLB grant after grant_dly cycles of ref_vld
task automatic run_walk(input logic [VPN_WIDTH-1:0] vpn, input ptw_acc_e acc, input int grant_dly);
  ptw_refill_t held;
  int          vld_cycles;
  logic        done;
  rd_addrs.delete();
  saw_vld    = 1'b0;
  vld_cycles = 0;
  done       = 1'b0;
  held       = '0;
  walk_req  <= 1'b1;
  walk_info <= '{vpn: vpn, acc: acc};
  @(posedge ptw_clk);
  walk_req <= 1'b0;
  while (!done)
  begin
    @(posedge ptw_clk);
    if (!walk_busy)
    begin
      $display("walk_busy low while a walk was still in progress");
      abort_run();
    end
    if (ref_vld)
    begin
      if (saw_vld)
        cmp_refill("ref_entry while waiting for grant", ref_entry, held);
      if (ref_cmplt && !ref_grant)
      begin
        $display("ref_cmplt rose while ref_vld was still waiting for ref_grant");
        abort_run();
      end
      held    = ref_entry;
      saw_vld = 1'b1;
      if (vld_cycles == grant_dly)
        ref_grant <= 1'b1;
      vld_cycles++;
    end
    if (ref_cmplt)
    begin
      got_status = {saw_vld, ref_acc_err, ref_pgflt, ref_data_vld};
      got_entry  = ref_entry;
      ref_grant <= 1'b0;
      done       = 1'b1;
    end
  end
  @(posedge ptw_clk);
  if (walk_busy)
  begin
    $display("walk_busy still high the cycle after ref_cmplt");
    abort_run();
  end
endtask

// build the three levels, walk, then check reads, status and refill
task automatic do_walk(input logic [VPN_WIDTH-1:0] vpn, input ptw_acc_e acc,
                       input logic [PTE_WIDTH-1:0] l1, input logic [PTE_WIDTH-1:0] l2,
                       input logic [PTE_WIDTH-1:0] l3, input int n_rd,
                       input logic [3:0] exp_st, input ptw_pgs_t pgs, input int grant_dly);
  logic [PADDR_WIDTH-1:0] exp_a [3];
  logic [PTE_WIDTH-1:0]   leaf;
  exp_a[0] = lvl_addr(SATP_PPN, vpn[26:18]);
  exp_a[1] = lvl_addr(l1[39:12], vpn[17:9]);
  exp_a[2] = lvl_addr(l2[39:12], vpn[8:0]);
  pt_mem.delete();
  pt_mem[exp_a[0]] = l1;
  pt_mem[exp_a[1]] = l2;
  pt_mem[exp_a[2]] = l3;
  run_walk(vpn, acc, grant_dly);
  if (rd_addrs.size() != n_rd)
  begin
    $display("walk made %0d memory reads, expected %0d", rd_addrs.size(), n_rd);
    abort_run();
  end
  for (int i = 0; i < n_rd; i++)
    cmp_addr("mem_addr", rd_addrs[i], exp_a[i]);
  cmp_status("{ref_vld seen, ref_acc_err, ref_pgflt, ref_data_vld}", got_status, exp_st);
  leaf = (n_rd == 1) ? l1 : ((n_rd == 2) ? l2 : l3);
  if (exp_st == ST_OK)
    cmp_refill("ref_entry", got_entry, exp_refill(leaf, vpn, pgs));
endtask

//========================================
// directed tests
//========================================
task automatic load_4k_page();
  logic [PTE_WIDTH-1:0] l3;
  // bit 6 clear and bit 12 set, so the two global bit sources differ
  l3 = make_pte(3'($urandom), 28'($urandom) | 28'h1, (12'($urandom) & 12'hfbf) | 12'h001);
  do_walk(27'($urandom), ACC_LOAD, make_pte(3'b000, 28'($urandom), 12'h001),
          make_pte(3'b000, 28'($urandom), 12'h001), l3, 3, ST_OK, '{0, 0, 1},
          $urandom_range(3, 0));
endtask

task automatic superpage_leaves();
  // 1g needs ppn bits 17:1 clear, 2m needs ppn bits 8:1 clear
  // 1g leaf has hg clear while its h bit is set
  do_walk(27'($urandom), ACC_LOAD, make_pte(3'b010, {10'($urandom), 17'h0, 1'b0}, 12'h1c1),
          '0, '0, 1, ST_OK, '{1, 0, 0}, $urandom_range(3, 0));
  do_walk(27'($urandom), ACC_LOAD, make_pte(3'b000, 28'($urandom), 12'h001),
          make_pte(3'b001, {19'($urandom), 8'h0, 1'b1}, 12'h0c1), '0, 2, ST_OK, '{0, 1, 0},
          $urandom_range(3, 0));
endtask

task automatic misaligned_superpages();
  do_walk(27'($urandom), ACC_LOAD, make_pte(3'b000, 28'($urandom), 12'h001),
          make_pte(3'b000, {19'($urandom), 8'h10, 1'b0}, 12'h1c1), '0, 2, ST_PGF, '0, 0);
  do_walk(27'($urandom), ACC_LOAD, make_pte(3'b000, {10'($urandom), 17'h0200, 1'b0}, 12'h1c1),
          '0, '0, 1, ST_PGF, '0, 0);
endtask

task automatic permission_faults();
  logic [PTE_WIDTH-1:0] l1;
  logic [PTE_WIDTH-1:0] l2;
  logic [VPN_WIDTH-1:0] vpn;
  l1  = make_pte(3'b000, 28'($urandom), 12'h001);
  l2  = make_pte(3'b000, 28'($urandom), 12'h001);
  vpn = 27'($urandom);
  // write clear
  do_walk(vpn, ACC_STORE, l1, l2, make_pte(3'b000, 28'($urandom), 12'h0c1), 3, ST_PGF, '0, 0);
  do_walk(vpn, ACC_LOAD, l1, l2, make_pte(3'b000, 28'($urandom), 12'h0c1), 3, ST_OK, '{0, 0, 1},
          $urandom_range(3, 0));
  // no-execute set
  do_walk(vpn, ACC_FETCH, l1, l2, make_pte(3'b100, 28'($urandom), 12'h1c1), 3, ST_PGF, '0, 0);
  do_walk(vpn, ACC_LOAD, l1, l2, make_pte(3'b100, 28'($urandom), 12'h1c1), 3, ST_OK, '{0, 0, 1},
          $urandom_range(3, 0));
  do_walk(vpn, ACC_LOAD, l1, l2, make_pte(3'b000, 28'($urandom), 12'h1c0), 3, ST_PGF, '0, 0);
endtask

task automatic bus_error_fault();
  logic [PTE_WIDTH-1:0] l1;
  logic [VPN_WIDTH-1:0] vpn;
  l1       = make_pte(3'b000, 28'($urandom), 12'h001);
  vpn      = 27'($urandom);
  err_addr = lvl_addr(l1[39:12], vpn[17:9]);
  err_en   = 1'b1;
  do_walk(vpn, ACC_LOAD, l1, make_pte(3'b000, 28'($urandom), 12'h001), '0, 2, ST_ACC, '0, 0);
  err_en   = 1'b0;
endtask

task automatic grant_backpressure();
  do_walk(27'($urandom), ACC_STORE, make_pte(3'b000, 28'($urandom), 12'h001),
          make_pte(3'b000, 28'($urandom), 12'h001),
          make_pte(3'($urandom), 28'($urandom), 12'h1c1), 3, ST_OK, '{0, 0, 1},
          $urandom_range(12, 4));
endtask

// ==== verif/ptw_tb.sv ====
// walker testbench top: clock, reset, DUT, memory responder, watchdog, test sequence
`default_nettype none

module ptw_tb;

  import ptw_pkg::*;

  localparam int                   CLK_PERIOD = 40;
  localparam int                   NUM_TESTS  = 6;
  localparam int                   WATCHDOG   = NUM_TESTS * 200 * CLK_PERIOD;
  localparam logic [31:0]          SEED       = 32'h03e4_4082;
  localparam logic [PPN_WIDTH-1:0] SATP_PPN   = 28'h008_0123;
  // status word: saw ref_vld, acc_err, pgflt, data_vld
  localparam logic [3:0]           ST_OK      = 4'b1001;
  localparam logic [3:0]           ST_PGF     = 4'b0010;
  localparam logic [3:0]           ST_ACC     = 4'b0100;

  logic                   ptw_clk;
  logic                   cpurst_b;
  logic                   walk_req;
  ptw_walk_req_t          walk_info;
  logic [PPN_WIDTH-1:0]   satp_ppn;
  logic                   walk_busy;
  logic                   mem_req;
  logic [PADDR_WIDTH-1:0] mem_addr;
  logic                   mem_vld;
  logic [PTE_WIDTH-1:0]   mem_data;
  logic                   mem_err;
  logic                   ref_vld;
  ptw_refill_t            ref_entry;
  logic                   ref_grant;
  logic                   ref_cmplt;
  logic                   ref_data_vld;
  logic                   ref_acc_err;
  logic                   ref_pgflt;

  // page table image and responder state
  logic [PTE_WIDTH-1:0]   pt_mem [logic [PADDR_WIDTH-1:0]];
  logic [PADDR_WIDTH-1:0] rd_addrs [$];
  logic [PADDR_WIDTH-1:0] err_addr;
  logic                   err_en;
  int unsigned            resp_dly [64];
  logic [3:0]             got_status;
  ptw_refill_t            got_entry;
  logic                   saw_vld;

  ptw_top ptw_top_i (.*);

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "ptw_tb_tasks.svh"

  initial
  begin
    ptw_clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) ptw_clk = ~ptw_clk;
  end

  //========================================
  // memory responder
  //========================================
  initial
  begin : mem_responder
    int                     n_req;
    logic [PADDR_WIDTH-1:0] req_addr;
    n_req = 0;
    forever
    begin
      @(posedge ptw_clk);
      if (mem_req)
      begin
        req_addr = mem_addr;
        rd_addrs.push_back(req_addr);
        repeat (resp_dly[n_req % 64]) @(posedge ptw_clk);
        n_req++;
        // address holds until the response
        cmp_addr("mem_addr", mem_addr, req_addr);
        if (err_en && (mem_addr == err_addr))
          mem_err <= 1'b1;
        else
        begin
          mem_vld  <= 1'b1;
          mem_data <= pt_mem.exists(mem_addr) ? pt_mem[mem_addr] : '0;
        end
        @(posedge ptw_clk);
        mem_vld <= 1'b0;
        mem_err <= 1'b0;
      end
    end
  end

  initial
  begin
    #(WATCHDOG);
    $display("timeout: walk never completed within %0d time units", WATCHDOG);
    abort_run();
  end

  //========================================
  // test sequence
  //========================================
  initial
  begin
    void'($urandom(SEED));
    foreach (resp_dly[i])
      resp_dly[i] = $urandom_range(5, 0);
    cpurst_b  = 1'b0;
    walk_req  = 1'b0;
    walk_info = '0;
    satp_ppn  = SATP_PPN;
    mem_vld   = 1'b0;
    mem_data  = '0;
    mem_err   = 1'b0;
    ref_grant = 1'b0;
    err_en    = 1'b0;
    err_addr  = '0;
    repeat (3) @(posedge ptw_clk);
    cpurst_b <= 1'b1;
    @(posedge ptw_clk);
    cmp_status("busy/req/vld/cmplt after reset", {walk_busy, mem_req, ref_vld, ref_cmplt}, 4'b0);
    load_4k_page();
    superpage_leaves();
    misaligned_superpages();
    permission_faults();
    bus_error_fault();
    grant_backpressure();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/ptw_pkg.sv
hw/ptw_walk_ctrl.sv
hw/ptw_addr_gen.sv
hw/ptw_pte_check.sv
hw/ptw_refill_out.sv
hw/ptw_top.sv
+incdir+verif
verif/ptw_tb.sv
